/* source/stream_pkg.sv */
`default_nettype none

package stream_pkg;

    // ------------------------------------------------------------------------
    // stream beat widths
    // ------------------------------------------------------------------------

    localparam int DATA_W = 32;

    // one keep bit per data byte
    localparam int KEEP_W = DATA_W / 8;

    // ------------------------------------------------------------------------
    // one beat of the frame stream
    // ------------------------------------------------------------------------

    // byte 0 of the beat sits in data[7:0]
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } axis_beat_t;

endpackage

`default_nettype wire

/* source/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    // ------------------------------------------------------------------------
    // header layout
    // ------------------------------------------------------------------------

    typedef logic [47:0] mac_t;

    typedef struct packed {
        mac_t        da;
        mac_t        sa;
        logic [15:0] length_type;
        logic [7:0]  ecn;
    } frame_hdr_t;

    // beat 3, high byte first
    typedef struct packed {
        logic [7:0]  label;
        logic [7:0]  ecn;
        logic [15:0] length_type;
    } tag_fields_t;

    typedef union packed {
        logic [31:0] raw;
        tag_fields_t fields;
    } tag_word_u;

    // DA/SA take three beats, the tag word the fourth
    localparam int HDR_WORDS = 4;

    localparam logic [7:0] ECN_ALERT = 8'h01;

    // ------------------------------------------------------------------------
    // port selection
    // ------------------------------------------------------------------------

    typedef logic [31:0] fill_level_t;

    // label 1 maps to port 0
    localparam logic [7:0] LABEL_FIRST = 8'd1;
    localparam logic [7:0] LABEL_NONE  = 8'hfe;

endpackage

`default_nettype wire

/* source/ingress_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_ctrl (
    input  wire logic                   glb_clk,
    input  wire logic                   glb_areset_n,
    input  wire logic                   s_tvalid,
    input  stream_pkg::axis_beat_t      s_beat,
    input  wire logic                   frame_done,
    output logic                        s_tready,
    output frame_pkg::frame_hdr_t       hdr,
    output logic                        tag_strobe,
    output logic [7:0]                  label,
    output stream_pkg::axis_beat_t      pay_beat,
    output logic                        pay_strobe
);
    import frame_pkg::*;

    localparam int CNT_W = $clog2(HDR_WORDS);

    typedef enum logic [1:0] {
        IN_IDLE,
        IN_HDR,
        IN_PAY,
        IN_WAIT
    } in_state_t;

    in_state_t        state;
    logic [CNT_W-1:0] beat_cnt;
    logic             accept;
    tag_word_u        tag_word;

    assign accept       = s_tvalid && s_tready;
    assign tag_word.raw = s_beat.data;

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            state      <= IN_IDLE;
            s_tready   <= 1'b0;
            beat_cnt   <= '0;
            tag_strobe <= 1'b0;
            pay_strobe <= 1'b0;
        end else begin
            tag_strobe <= 1'b0;
            pay_strobe <= 1'b0;
            case (state)
                IN_IDLE: begin
                    if (s_tvalid) begin
                        s_tready <= 1'b1;
                        beat_cnt <= '0;
                        state    <= IN_HDR;
                    end
                end
                IN_HDR: begin
                    if (accept) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == CNT_W'(HDR_WORDS - 1)) begin
                            tag_strobe <= 1'b1;
                            state      <= IN_PAY;
                        end
                    end
                end
                IN_PAY: begin
                    if (accept) begin
                        pay_strobe <= 1'b1;
                        if (s_beat.last) begin
                            s_tready <= 1'b0;
                            state    <= IN_WAIT;
                        end
                    end
                end
                // hold off the next frame until the output side is done
                IN_WAIT: begin
                    if (frame_done) begin
                        state <= IN_IDLE;
                    end
                end
                default: state <= IN_IDLE;
            endcase
        end
    end

    // header fields and payload forwarding
    always_ff @(posedge glb_clk) begin
        if (accept && state == IN_HDR) begin
            case (beat_cnt)
                CNT_W'(0): hdr.da[31:0] <= s_beat.data;
                CNT_W'(1): begin
                    hdr.da[47:32] <= s_beat.data[15:0];
                    hdr.sa[15:0]  <= s_beat.data[31:16];
                end
                CNT_W'(2): hdr.sa[47:16] <= s_beat.data;
                default: begin
                    hdr.length_type <= tag_word.fields.length_type;
                    hdr.ecn         <= tag_word.fields.ecn;
                    label           <= tag_word.fields.label;
                end
            endcase
        end
        if (accept && state == IN_PAY) begin
            pay_beat <= s_beat;
        end
    end

endmodule

`default_nettype wire

/* source/port_select.sv */
`timescale 1ns/1ps
`default_nettype none

module port_select #(
    parameter int                     PORT_NUM             = 32,
    parameter frame_pkg::fill_level_t FILL_ALERT_THRESHOLD = 3000
) (
    input  wire logic                                glb_clk,
    input  wire logic                                glb_areset_n,
    input  wire logic [7:0]                          label,
    input  wire logic                                tag_strobe,
    input  wire logic                                frame_done,
    input  frame_pkg::fill_level_t [PORT_NUM-1:0]    fifo_fill,
    output logic [PORT_NUM-1:0]                      bus_sel,
    output logic                                     ecn_mark
);
    import frame_pkg::*;

    logic [7:0] label_r;

    // label of the frame in flight, parked on a non-port value otherwise
    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            label_r <= LABEL_NONE;
        end else if (frame_done) begin
            label_r <= LABEL_NONE;
        end else if (tag_strobe) begin
            label_r <= label;
        end
    end

    // one-hot decode and fill check on the selected port
    always_comb begin
        bus_sel  = '0;
        ecn_mark = 1'b0;
        for (int i = 0; i < PORT_NUM; i++) begin
            if (label_r == LABEL_FIRST + 8'(i)) begin
                bus_sel[i] = 1'b1;
                ecn_mark   = fifo_fill[i] > FILL_ALERT_THRESHOLD;
            end
        end
    end

endmodule

`default_nettype wire

/* source/byte_realigner.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_realigner (
    input  wire logic                 glb_clk,
    input  wire logic                 glb_areset_n,
    input  stream_pkg::axis_beat_t    pay_beat,
    input  wire logic                 pay_strobe,
    output logic [7:0]                first_byte,
    output logic                      first_strobe,
    output stream_pkg::axis_beat_t    shifted_beat,
    output logic                      shifted_valid
);
    import stream_pkg::*;
    import frame_pkg::*;

    logic              in_frame;
    logic              tail_pend;
    logic              multi_tail;
    logic [DATA_W-9:0] held;
    logic [KEEP_W-1:0] tail_keep;

    axis_beat_t             stage_in;
    logic                   stage_in_v;
    axis_beat_t             dly [HDR_WORDS];
    logic [HDR_WORDS-1:0]   dly_v;

    // last beat still has bytes left once its low byte moves down
    assign multi_tail = |pay_beat.keep[KEEP_W-1:1];

    // ------------------------------------------------------------------------
    // shift down by one byte
    // ------------------------------------------------------------------------

    always_comb begin
        stage_in.data = {pay_beat.data[7:0], held};
        stage_in.keep = '1;
        stage_in.last = pay_beat.last && !multi_tail;
        stage_in_v    = pay_strobe && in_frame;
        // flush of the upper bytes of the last beat
        if (!pay_strobe && tail_pend) begin
            stage_in.data = {8'h00, held};
            stage_in.keep = tail_keep;
            stage_in.last = 1'b1;
            stage_in_v    = 1'b1;
        end
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            in_frame     <= 1'b0;
            tail_pend    <= 1'b0;
            first_strobe <= 1'b0;
            dly_v        <= '0;
        end else begin
            first_strobe <= pay_strobe && !in_frame;
            if (pay_strobe) begin
                if (!in_frame) begin
                    in_frame <= 1'b1;
                end else if (pay_beat.last) begin
                    in_frame  <= 1'b0;
                    tail_pend <= multi_tail;
                end
            end else begin
                tail_pend <= 1'b0;
            end
            dly_v <= {dly_v[HDR_WORDS-2:0], stage_in_v};
        end
    end

    // ------------------------------------------------------------------------
    // byte holding and delay line
    // ------------------------------------------------------------------------

    always_ff @(posedge glb_clk) begin
        if (pay_strobe) begin
            held      <= pay_beat.data[DATA_W-1:8];
            tail_keep <= pay_beat.keep >> 1;
            if (!in_frame) begin
                first_byte <= pay_beat.data[7:0];
            end
        end
        dly[0] <= stage_in;
        for (int i = 1; i < HDR_WORDS; i++) begin
            dly[i] <= dly[i-1];
        end
    end

    // lines up behind the rebuilt header
    assign shifted_beat  = dly[HDR_WORDS-1];
    assign shifted_valid = dly_v[HDR_WORDS-1];

endmodule

`default_nettype wire

/* source/egress_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_sequencer (
    input  wire logic                 glb_clk,
    input  wire logic                 glb_areset_n,
    input  frame_pkg::frame_hdr_t     hdr,
    input  wire logic                 ecn_mark,
    input  wire logic [7:0]           first_byte,
    input  wire logic                 first_strobe,
    input  stream_pkg::axis_beat_t    shifted_beat,
    input  wire logic                 shifted_valid,
    input  wire logic                 m_tready,
    output logic                      m_tvalid,
    output stream_pkg::axis_beat_t    m_beat,
    output logic                      frame_done
);
    import stream_pkg::*;
    import frame_pkg::*;

    typedef enum logic [2:0] {
        EG_IDLE,
        EG_DA0,
        EG_DA1_SA0,
        EG_SA1,
        EG_TAG,
        EG_DATA,
        EG_DROP
    } eg_state_t;

    eg_state_t  state;
    logic [7:0] first_r;
    tag_word_u  out_tag;

    function automatic axis_beat_t hdr_beat(input logic [DATA_W-1:0] word);
        axis_beat_t beat;
        beat.data = word;
        beat.keep = '1;
        beat.last = 1'b0;
        return beat;
    endfunction

    // first payload byte takes the label slot
    always_comb begin
        out_tag.fields.label       = first_r;
        out_tag.fields.ecn         = ecn_mark ? ECN_ALERT : hdr.ecn;
        out_tag.fields.length_type = hdr.length_type;
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n) begin
        if (!glb_areset_n) begin
            state      <= EG_IDLE;
            m_tvalid   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                EG_IDLE: begin
                    if (first_strobe) begin
                        m_tvalid <= 1'b1;
                        state    <= EG_DA0;
                    end
                end
                // sink gets one chance, at DA0
                EG_DA0: begin
                    if (m_tready) begin
                        state <= EG_DA1_SA0;
                    end else begin
                        m_tvalid <= 1'b0;
                        state    <= EG_DROP;
                    end
                end
                EG_DA1_SA0: state <= EG_SA1;
                EG_SA1:     state <= EG_TAG;
                EG_TAG: begin
                    m_tvalid <= shifted_valid;
                    state    <= EG_DATA;
                end
                EG_DATA: begin
                    if (m_beat.last) begin
                        m_tvalid   <= 1'b0;
                        frame_done <= 1'b1;
                        state      <= EG_IDLE;
                    end else begin
                        m_tvalid <= shifted_valid;
                    end
                end
                // drain the payload without sending it
                EG_DROP: begin
                    if (shifted_valid && shifted_beat.last) begin
                        frame_done <= 1'b1;
                        state      <= EG_IDLE;
                    end
                end
                default: state <= EG_IDLE;
            endcase
        end
    end

    always_ff @(posedge glb_clk) begin
        if (first_strobe) begin
            first_r <= first_byte;
        end
        case (state)
            EG_IDLE:    m_beat <= hdr_beat(hdr.da[31:0]);
            EG_DA0:     m_beat <= hdr_beat({hdr.sa[15:0], hdr.da[47:32]});
            EG_DA1_SA0: m_beat <= hdr_beat(hdr.sa[47:16]);
            EG_SA1:     m_beat <= hdr_beat(out_tag.raw);
            EG_TAG,
            EG_DATA:    m_beat <= shifted_beat;
            default:    m_beat <= m_beat;
        endcase
    end

endmodule

`default_nettype wire

/* source/frame_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_decoder #(
    parameter int                     PORT_NUM             = 32,
    parameter frame_pkg::fill_level_t FILL_ALERT_THRESHOLD = 3000
) (
    input  wire logic                                glb_clk,
    input  wire logic                                glb_areset_n,
    input  wire logic                                s_tvalid,
    output logic                                     s_tready,
    input  stream_pkg::axis_beat_t                   s_beat,
    output logic                                     m_tvalid,
    input  wire logic                                m_tready,
    output stream_pkg::axis_beat_t                   m_beat,
    output logic [PORT_NUM-1:0]                      bus_sel,
    input  frame_pkg::fill_level_t [PORT_NUM-1:0]    fifo_fill
);
    import stream_pkg::*;
    import frame_pkg::*;

    frame_hdr_t hdr;
    logic       tag_strobe;
    logic [7:0] label;
    axis_beat_t pay_beat;
    logic       pay_strobe;
    logic       ecn_mark;
    logic [7:0] first_byte;
    logic       first_strobe;
    axis_beat_t shifted_beat;
    logic       shifted_valid;
    logic       frame_done;

    ingress_ctrl u_ingress_ctrl (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_tvalid     (s_tvalid),
        .s_beat       (s_beat),
        .frame_done   (frame_done),
        .s_tready     (s_tready),
        .hdr          (hdr),
        .tag_strobe   (tag_strobe),
        .label        (label),
        .pay_beat     (pay_beat),
        .pay_strobe   (pay_strobe)
    );

    port_select #(
        .PORT_NUM             (PORT_NUM),
        .FILL_ALERT_THRESHOLD (FILL_ALERT_THRESHOLD)
    ) u_port_select (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .label        (label),
        .tag_strobe   (tag_strobe),
        .frame_done   (frame_done),
        .fifo_fill    (fifo_fill),
        .bus_sel      (bus_sel),
        .ecn_mark     (ecn_mark)
    );

    byte_realigner u_byte_realigner (
        .glb_clk       (glb_clk),
        .glb_areset_n  (glb_areset_n),
        .pay_beat      (pay_beat),
        .pay_strobe    (pay_strobe),
        .first_byte    (first_byte),
        .first_strobe  (first_strobe),
        .shifted_beat  (shifted_beat),
        .shifted_valid (shifted_valid)
    );

    egress_sequencer u_egress_sequencer (
        .glb_clk       (glb_clk),
        .glb_areset_n  (glb_areset_n),
        .hdr           (hdr),
        .ecn_mark      (ecn_mark),
        .first_byte    (first_byte),
        .first_strobe  (first_strobe),
        .shifted_beat  (shifted_beat),
        .shifted_valid (shifted_valid),
        .m_tready      (m_tready),
        .m_tvalid      (m_tvalid),
        .m_beat        (m_beat),
        .frame_done    (frame_done)
    );

endmodule

`default_nettype wire

/* verification/frame_decoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_decoder_tb;
    import stream_pkg::*;
    import frame_pkg::*;

    localparam int          PORT_NUM       = 32;
    localparam fill_level_t FILL_THRESHOLD = 3000;
    localparam int          NUM_FRAMES     = 14;
    localparam int          NUM_FIELDS     = 7;
    localparam int          WAIT_LIMIT     = 200;

    logic                       glb_clk = 1'b0;
    logic                       glb_areset_n;
    logic                       s_tvalid;
    logic                       s_tready;
    axis_beat_t                 s_beat;
    logic                       m_tvalid;
    logic                       m_tready;
    axis_beat_t                 m_beat;
    logic [PORT_NUM-1:0]        bus_sel;
    fill_level_t [PORT_NUM-1:0] fifo_fill;

    logic [31:0]         vec_mem [NUM_FRAMES*NUM_FIELDS];
    logic [31:0]         lfsr = 32'h87cf;
    logic [7:0]          in_bytes [$];
    logic [7:0]          exp_bytes [$];
    logic [PORT_NUM-1:0] exp_sel;
    logic                exp_mark;
    logic                sink_ready;
    int                  num_in_beats;
    int                  num_out_beats;
    string               frame_name;

    frame_decoder #(
        .PORT_NUM             (PORT_NUM),
        .FILL_ALERT_THRESHOLD (FILL_THRESHOLD)
    ) DUT (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .s_beat       (s_beat),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .m_beat       (m_beat),
        .bus_sel      (bus_sel),
        .fifo_fill    (fifo_fill)
    );

    always #4 glb_clk = ~glb_clk;

    // ------------------------------------------------------------------------
    // random bytes and checks
    // ------------------------------------------------------------------------

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    // beat idx of a byte stream, unused bytes zero
    function automatic axis_beat_t pack_beat(input logic [7:0] bytes [$], input int idx);
        axis_beat_t beat;
        beat = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            if (4 * idx + i < bytes.size()) begin
                beat.data[8*i +: 8] = bytes[4*idx+i];
                beat.keep[i]        = 1'b1;
            end
        end
        beat.last = (4 * idx + KEEP_W >= bytes.size());
        return beat;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
        axis_beat_t seen;
        seen = act;
        // bytes outside keep carry no data
        for (int i = 0; i < KEEP_W; i++) begin
            if (!exp.keep[i]) begin
                seen.data[8*i +: 8] = 8'h00;
            end
        end
        if (seen !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_sel(input string name, input logic [PORT_NUM-1:0] exp,
                             input logic [PORT_NUM-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ------------------------------------------------------------------------
    // frame setup, driver and monitors
    // ------------------------------------------------------------------------

    task automatic load_frame(input int f);
        int          base;
        int          lbl;
        int          pay_len;
        logic [31:0] hot_port;
        logic [31:0] hot_fill;
        logic [15:0] len_type;
        base       = f * NUM_FIELDS;
        lbl        = int'(vec_mem[base][7:0]);
        len_type   = vec_mem[base+2][15:0];
        pay_len    = int'(vec_mem[base+3]);
        hot_port   = vec_mem[base+4];
        hot_fill   = vec_mem[base+5];
        sink_ready = vec_mem[base+6][0];
        frame_name = $sformatf("frame %0d label %02h", f, lbl);
        if (pay_len < 5) begin
            abort_run($sformatf("vector line %0d has a payload shorter than 5 bytes", f));
        end
        exp_sel  = '0;
        exp_mark = 1'b0;
        if (lbl >= 1 && lbl <= PORT_NUM) begin
            exp_sel[lbl-1] = 1'b1;
            exp_mark       = (int'(hot_port) == lbl - 1) && (hot_fill > FILL_THRESHOLD);
        end
        in_bytes.delete();
        for (int i = 0; i < 12; i++) begin
            in_bytes.push_back(rand_byte());
        end
        in_bytes.push_back(len_type[7:0]);
        in_bytes.push_back(len_type[15:8]);
        in_bytes.push_back(vec_mem[base+1][7:0]);
        in_bytes.push_back(vec_mem[base][7:0]);
        for (int i = 0; i < pay_len; i++) begin
            in_bytes.push_back(rand_byte());
        end
        // label byte goes, everything after it moves down
        exp_bytes = in_bytes;
        exp_bytes.delete(15);
        if (exp_mark) begin
            exp_bytes[14] = 8'h01;
        end
        num_in_beats  = (in_bytes.size() + 3) / 4;
        num_out_beats = (exp_bytes.size() + 3) / 4;
        fifo_fill     = '0;
        fifo_fill[hot_port[4:0]] = hot_fill;
        m_tready      = sink_ready;
    endtask

    task automatic send_frame();
        int waited;
        s_tvalid = 1'b1;
        for (int i = 0; i < num_in_beats; i++) begin
            s_beat = pack_beat(in_bytes, i);
            waited = 0;
            while (!s_tready) begin
                @(negedge glb_clk);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    abort_run($sformatf("%s: s_tready never rose for input beat %0d",
                                        frame_name, i));
                end
            end
            // taken on the coming rising edge
            @(negedge glb_clk);
        end
        s_tvalid = 1'b0;
        s_beat   = '0;
        check_flag($sformatf("%s s_tready after tlast", frame_name), 1'b0, s_tready);
    endtask

    task automatic wait_first_beat();
        int waited;
        waited = 0;
        while (!m_tvalid) begin
            @(negedge glb_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run($sformatf("%s: no output beat appeared", frame_name));
            end
        end
        check_sel($sformatf("%s bus_sel in flight", frame_name), exp_sel, bus_sel);
    endtask

    task automatic wait_sel_clear(input logic in_drop);
        int waited;
        waited = 0;
        while (bus_sel != '0) begin
            @(negedge glb_clk);
            waited++;
            if (in_drop) begin
                check_flag($sformatf("%s m_tvalid while dropping", frame_name), 1'b0, m_tvalid);
            end
            if (waited > WAIT_LIMIT) begin
                abort_run($sformatf("%s: bus_sel did not clear after the frame", frame_name));
            end
        end
    endtask

    task automatic receive_frame();
        wait_first_beat();
        for (int i = 0; i < num_out_beats; i++) begin
            if (i > 0) begin
                @(negedge glb_clk);
            end
            check_flag($sformatf("%s m_tvalid beat %0d", frame_name, i), 1'b1, m_tvalid);
            check_beat($sformatf("%s beat %0d", frame_name, i), pack_beat(exp_bytes, i), m_beat);
        end
        @(negedge glb_clk);
        check_flag($sformatf("%s m_tvalid after tlast", frame_name), 1'b0, m_tvalid);
        wait_sel_clear(1'b0);
    endtask

    // sink refuses DA0, nothing more may be offered
    task automatic watch_drop();
        wait_first_beat();
        @(negedge glb_clk);
        check_flag($sformatf("%s m_tvalid after refused DA0", frame_name), 1'b0, m_tvalid);
        wait_sel_clear(1'b1);
    endtask

    initial begin
        glb_areset_n = 1'b0;
        s_tvalid     = 1'b0;
        s_beat       = '0;
        m_tready     = 1'b0;
        fifo_fill    = '0;
        $readmemh("verification/frame_vectors.txt", vec_mem);
        repeat (4) @(negedge glb_clk);
        glb_areset_n = 1'b1;
        @(negedge glb_clk);
        check_flag("reset s_tready", 1'b0, s_tready);
        check_flag("reset m_tvalid", 1'b0, m_tvalid);
        check_sel("reset bus_sel", '0, bus_sel);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            load_frame(f);
            fork
                send_frame();
                begin
                    if (sink_ready) begin
                        receive_frame();
                    end else begin
                        watch_drop();
                    end
                end
            join
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/frame_vectors.txt */
// label ecn length_type payload_bytes hot_port hot_fill sink_ready
// all hex, one frame per line; drop frames keep a label inside 1..32
01 00 0800 05 00 00000000 1
02 03 86dd 06 01 00000bb9 1
20 02 0800 07 1f 00001000 1
05 02 0806 08 04 00000bb8 1
06 03 0800 09 07 0000ffff 1
00 01 0800 0a 00 0000ffff 1
fe 02 0800 0b 00 0000ffff 1
ff 00 88cc 0c 1e 0000ffff 1
03 00 0800 10 02 00000bb9 0
04 00 0800 0d 03 00000000 1
21 01 0800 0e 00 0000ffff 1
10 00 0800 21 0f 00000bb9 1
07 00 0800 05 06 00000000 0
08 02 0800 06 07 00000000 1

/* list.f */
source/stream_pkg.sv
source/frame_pkg.sv
source/ingress_ctrl.sv
source/port_select.sv
source/byte_realigner.sv
source/egress_sequencer.sv
source/frame_decoder.sv
verification/frame_decoder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the frame_decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -f list.f --top-module frame_decoder_tb \
    --Mdir obj_dir -o frame_decoder_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/frame_decoder_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "result: testbench reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "result: simulator exited with status $sim_status"
    exit 1
fi
echo "result: ok"
exit 0
